// File: Bender.yml
package:
  name: snowball_cache

sources:
  - include_dirs:
      - include
    files:
      - design/snowball_pkg.sv
      - design/snowball_tlb.sv
      - design/snowball_cache_array.sv
      - design/snowball_cache_ctrl.sv
      - design/snowball_bus_unit.sv
      - design/snowball_cache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/snowball_checker.sv
      - sim/snowball_tb.sv

// File: design/snowball_bus_unit.sv
// Memory and DMA bus unit
`timescale 1ns/1ps
`default_nettype none
`include "snowball_defines.svh"

module snowball_bus_unit
(
  input  wire                          CPU_CLK,
  input  wire                          RST,
  input  wire                          bus_start,
  input  wire  snowball_pkg::bus_req_t bus_req,
  output snowball_pkg::bus_rsp_t       bus_rsp,
  // memory port
  output logic [`SNOWBALL_ADDR_W-1:0]  mem_addr,
  output logic                         mem_we,
  output logic                         mem_do_act,
  output logic [`SNOWBALL_ADDR_W-1:0]  mem_dataintomem,
  input  wire                          mem_ack,
  input  wire  [`SNOWBALL_ADDR_W-1:0]  mem_datafrommem,
  // DMA port
  output logic                         dma_wrte,
  output logic                         dma_read,
  input  wire                          dma_wrte_ack,
  input  wire                          dma_read_ack,
  input  wire  [`SNOWBALL_ADDR_W-1:0]  dma_data_read
);

  snowball_pkg::bus_state_e    state;
  logic                        dma_sel;
  logic                        dma_ack;
  logic                        accept;
  logic                        done_q;
  logic [`SNOWBALL_ADDR_W-1:0] data_q;

  assign dma_sel = (bus_req.addr[`SNOWBALL_ADDR_W-1 -: 2] == `SNOWBALL_DMA_REGION);
  assign dma_ack = (dma_wrte && dma_wrte_ack) || (dma_read && dma_read_ack);
  assign accept  = bus_start && (state == snowball_pkg::BUS_IDLE);

  // ------------------------------------------------------------
  // target strobes, held until acknowledged
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state      <= snowball_pkg::BUS_IDLE;
      mem_do_act <= 1'b0;
      mem_we     <= 1'b0;
      dma_wrte   <= 1'b0;
      dma_read   <= 1'b0;
      done_q     <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state)
        snowball_pkg::BUS_IDLE:
          if (accept && dma_sel)
          begin
            dma_wrte <= bus_req.we;
            dma_read <= !bus_req.we;
            state    <= snowball_pkg::BUS_DMA;
          end
          else if (accept)
          begin
            mem_do_act <= 1'b1;
            mem_we     <= bus_req.we;
            state      <= snowball_pkg::BUS_MEM;
          end
        snowball_pkg::BUS_MEM:
          if (mem_ack)
          begin
            mem_do_act <= 1'b0; // dropped the cycle after ack
            mem_we     <= 1'b0;
            done_q     <= 1'b1;
            state      <= snowball_pkg::BUS_IDLE;
          end
        default:
          if (dma_ack)
          begin
            dma_wrte <= 1'b0;
            dma_read <= 1'b0;
            done_q   <= 1'b1;
            state    <= snowball_pkg::BUS_IDLE;
          end
      endcase
    end
  end

  // address, write data and read capture
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      mem_addr        <= bus_req.addr;
      mem_dataintomem <= bus_req.data;
    end
    if ((state == snowball_pkg::BUS_MEM) && mem_ack)
      data_q <= mem_datafrommem; // taken in the ack cycle
    else if (dma_read && dma_read_ack)
      data_q <= dma_data_read;
  end

  assign bus_rsp = '{done: done_q, data: data_q};

endmodule

`default_nettype wire

// File: design/snowball_cache_array.sv
// Cache data and tag storage
`timescale 1ns/1ps
`default_nettype none
`include "snowball_defines.svh"

module snowball_cache_array
(
  input  wire                          CPU_CLK,
  input  wire                          RST,
  input  wire  [`SNOWBALL_IDX_W-1:0]   rd_idx,
  input  wire                          rd_en,
  input  wire                          wr_en,
  input  wire  [`SNOWBALL_IDX_W-1:0]   wr_idx,
  input  wire  [`SNOWBALL_TAG_W-1:0]   wr_tag,
  input  wire  [`SNOWBALL_ADDR_W-1:0]  wr_data,
  input  wire  [`SNOWBALL_TAG_W-1:0]   cmp_tag,
  output logic                         hit,
  output logic [`SNOWBALL_ADDR_W-1:0]  rd_data
);

  logic [`SNOWBALL_ADDR_W-1:0] data_mem [0:`SNOWBALL_DEPTH-1];
  logic [`SNOWBALL_TAG_W-1:0]  tag_mem  [0:`SNOWBALL_DEPTH-1];
  logic [`SNOWBALL_DEPTH-1:0]  valid;
  logic [`SNOWBALL_TAG_W-1:0]  tag_q;
  logic                        valid_q;

  // ------------------------------------------------------------
  // storage, read registered on rd_en
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
    if (rd_en)
    begin
      rd_data <= data_mem[rd_idx];
      tag_q   <= tag_mem[rd_idx];
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid   <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (wr_en)
        valid[wr_idx] <= 1'b1; // lines only ever become valid
      if (rd_en)
        valid_q <= valid[rd_idx];
    end
  end

  assign hit = valid_q && (tag_q == cmp_tag);

endmodule

`default_nettype wire

// File: design/snowball_cache_ctrl.sv
// Cache controller
`timescale 1ns/1ps
`default_nettype none
`include "snowball_defines.svh"

module snowball_cache_ctrl
(
  input  wire                          CPU_CLK,
  input  wire                          RST,
  // CPU port
  input  wire                          cache_precycle_enable,
  input  wire  [`SNOWBALL_ADDR_W-1:0]  cache_precycle_addr,
  input  wire                          cache_precycle_we,
  input  wire                          cache_precycle_force_miss,
  input  wire  [`SNOWBALL_ADDR_W-1:0]  cache_datao,
  input  wire                          cache_inhibit,
  input  wire                          WE_TLB,
  output logic [`SNOWBALL_ADDR_W-1:0]  cache_datai,
  output logic                         cache_busy,
  output logic                         MMU_FAULT,
  // storage lookup, shared read enable
  output logic                         lookup_en,
  output logic [`SNOWBALL_IDX_W-1:0]   arr_rd_idx,
  output logic [`SNOWBALL_IDX_W-1:0]   tlb_rd_idx,
  output logic [`SNOWBALL_TAG_W-1:0]   cmp_tag,
  output logic [`SNOWBALL_PAGE_W-1:0]  vpage,
  input  wire                          hit,
  input  wire  [`SNOWBALL_ADDR_W-1:0]  rd_data,
  input  wire  [`SNOWBALL_PAGE_W-1:0]  ppage,
  input  wire                          fault,
  // storage updates
  output logic                         arr_wr_en,
  output logic [`SNOWBALL_IDX_W-1:0]   arr_wr_idx,
  output logic [`SNOWBALL_TAG_W-1:0]   arr_wr_tag,
  output logic [`SNOWBALL_ADDR_W-1:0]  arr_wr_data,
  output logic                         tlb_wr_en,
  output logic [`SNOWBALL_IDX_W-1:0]   tlb_wr_idx,
  output logic [`SNOWBALL_ADDR_W-1:0]  tlb_wr_entry,
  // bus unit
  output logic                         bus_start,
  output snowball_pkg::bus_req_t       bus_req,
  input  wire  snowball_pkg::bus_rsp_t bus_rsp
);

  snowball_pkg::ctrl_state_e   state;
  snowball_pkg::cache_req_t    req_q;
  snowball_pkg::bus_req_t      bus_q;
  logic [`SNOWBALL_ADDR_W-1:0] phys_addr;
  logic                        idle;
  logic                        read_hit;
  logic                        fill_done;

  assign idle = (state == snowball_pkg::CTRL_IDLE);

  // ------------------------------------------------------------
  // precycle: start the synchronous reads
  // ------------------------------------------------------------
  // only one request in flight, strobes outside idle are ignored
  assign lookup_en  = cache_precycle_enable && !cache_inhibit && idle;
  assign arr_rd_idx = cache_precycle_addr[`SNOWBALL_IDX_W-1:0];
  assign tlb_rd_idx = cache_precycle_addr[2*`SNOWBALL_IDX_W-1:`SNOWBALL_IDX_W];

  // table write index is the low address byte
  assign tlb_wr_en    = WE_TLB && idle;
  assign tlb_wr_idx   = cache_precycle_addr[`SNOWBALL_IDX_W-1:0];
  assign tlb_wr_entry = cache_datao;

  // ------------------------------------------------------------
  // lookup cycle
  // ------------------------------------------------------------
  assign vpage     = req_q.addr[`SNOWBALL_ADDR_W-1:`SNOWBALL_PAGE_W];
  assign phys_addr = {ppage, req_q.addr[`SNOWBALL_PAGE_W-1:0]};
  assign cmp_tag   = phys_addr[`SNOWBALL_ADDR_W-1:`SNOWBALL_IDX_W];
  assign read_hit  = hit && !req_q.we && !req_q.force_miss;

  // write-allocate, the line takes whatever crossed the bus
  assign fill_done   = (state == snowball_pkg::CTRL_FILL) && bus_rsp.done;
  assign arr_wr_en   = fill_done;
  assign arr_wr_idx  = bus_q.addr[`SNOWBALL_IDX_W-1:0];
  assign arr_wr_tag  = bus_q.addr[`SNOWBALL_ADDR_W-1:`SNOWBALL_IDX_W];
  assign arr_wr_data = bus_q.we ? bus_q.data : bus_rsp.data;

  assign bus_start = (state == snowball_pkg::CTRL_BUS);
  assign bus_req   = bus_q;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state      <= snowball_pkg::CTRL_IDLE;
      cache_busy <= 1'b0;
      MMU_FAULT  <= 1'b0;
    end
    else
    begin
      MMU_FAULT <= 1'b0; // single cycle pulse
      case (state)
        snowball_pkg::CTRL_IDLE:
          if (lookup_en)
            state <= snowball_pkg::CTRL_LOOKUP;
        snowball_pkg::CTRL_LOOKUP:
        begin
          if (fault)
          begin
            MMU_FAULT <= 1'b1; // access suppressed
            state     <= snowball_pkg::CTRL_IDLE;
          end
          else if (read_hit)
            state <= snowball_pkg::CTRL_IDLE;
          else
          begin
            cache_busy <= 1'b1;
            state      <= snowball_pkg::CTRL_BUS;
          end
        end
        snowball_pkg::CTRL_BUS:
          state <= snowball_pkg::CTRL_FILL;
        default:
          if (bus_rsp.done)
          begin
            cache_busy <= 1'b0;
            state      <= snowball_pkg::CTRL_IDLE;
          end
      endcase
    end
  end

  // request and return data registers
  always_ff @(posedge CPU_CLK)
  begin
    if (lookup_en)
      req_q <= '{addr: cache_precycle_addr, data: cache_datao,
                 we: cache_precycle_we, force_miss: cache_precycle_force_miss};
    if ((state == snowball_pkg::CTRL_LOOKUP) && !fault)
    begin
      if (read_hit)
        cache_datai <= rd_data;
      bus_q <= '{addr: phys_addr, data: req_q.data, we: req_q.we};
    end
    if (fill_done && !bus_q.we)
      cache_datai <= bus_rsp.data;
  end

endmodule

`default_nettype wire

// File: design/snowball_cache_top.sv
// Cache subsystem top level
`timescale 1ns/1ps
`default_nettype none
`include "snowball_defines.svh"

module snowball_cache_top
(
  input  wire                          CPU_CLK,
  input  wire                          RST,
  // CPU port
  input  wire  [`SNOWBALL_ADDR_W-1:0]  cache_precycle_addr,
  input  wire  [`SNOWBALL_ADDR_W-1:0]  cache_datao,
  output logic [`SNOWBALL_ADDR_W-1:0]  cache_datai,
  input  wire                          cache_precycle_we,
  output logic                         cache_busy,
  input  wire                          cache_precycle_enable,
  input  wire                          cache_precycle_force_miss,
  input  wire                          VMEM_ACT,
  input  wire                          cache_inhibit,
  output logic                         MMU_FAULT,
  input  wire                          WE_TLB,
  // memory port
  output logic [`SNOWBALL_ADDR_W-1:0]  mem_addr,
  output logic                         mem_we,
  output logic                         mem_do_act,
  output logic [`SNOWBALL_ADDR_W-1:0]  mem_dataintomem,
  input  wire                          mem_ack,
  input  wire  [`SNOWBALL_ADDR_W-1:0]  mem_datafrommem,
  // DMA port
  output logic                         dma_wrte,
  output logic                         dma_read,
  input  wire                          dma_wrte_ack,
  input  wire                          dma_read_ack,
  input  wire  [`SNOWBALL_ADDR_W-1:0]  dma_data_read
);

  logic                        lookup_en;
  logic [`SNOWBALL_IDX_W-1:0]  arr_rd_idx;
  logic [`SNOWBALL_IDX_W-1:0]  tlb_rd_idx;
  logic [`SNOWBALL_TAG_W-1:0]  cmp_tag;
  logic [`SNOWBALL_PAGE_W-1:0] vpage;
  logic                        hit;
  logic [`SNOWBALL_ADDR_W-1:0] rd_data;
  logic [`SNOWBALL_PAGE_W-1:0] ppage;
  logic                        fault;
  logic                        arr_wr_en;
  logic [`SNOWBALL_IDX_W-1:0]  arr_wr_idx;
  logic [`SNOWBALL_TAG_W-1:0]  arr_wr_tag;
  logic [`SNOWBALL_ADDR_W-1:0] arr_wr_data;
  logic                        tlb_wr_en;
  logic [`SNOWBALL_IDX_W-1:0]  tlb_wr_idx;
  logic [`SNOWBALL_ADDR_W-1:0] tlb_wr_entry;
  logic                        bus_start;
  snowball_pkg::bus_req_t      bus_req;
  snowball_pkg::bus_rsp_t      bus_rsp;

  snowball_tlb u_tlb
  (
    .CPU_CLK  (CPU_CLK),
    .RST      (RST),
    .rd_idx   (tlb_rd_idx),
    .rd_en    (lookup_en),
    .wr_en    (tlb_wr_en),
    .wr_idx   (tlb_wr_idx),
    .wr_entry (tlb_wr_entry),
    .vpage    (vpage),
    .vmem     (VMEM_ACT),
    .ppage    (ppage),
    .fault    (fault)
  );

  snowball_cache_array u_array
  (
    .CPU_CLK (CPU_CLK),
    .RST     (RST),
    .rd_idx  (arr_rd_idx),
    .rd_en   (lookup_en),
    .wr_en   (arr_wr_en),
    .wr_idx  (arr_wr_idx),
    .wr_tag  (arr_wr_tag),
    .wr_data (arr_wr_data),
    .cmp_tag (cmp_tag),
    .hit     (hit),
    .rd_data (rd_data)
  );

  snowball_cache_ctrl u_ctrl
  (
    .CPU_CLK                   (CPU_CLK),
    .RST                       (RST),
    .cache_precycle_enable     (cache_precycle_enable),
    .cache_precycle_addr       (cache_precycle_addr),
    .cache_precycle_we         (cache_precycle_we),
    .cache_precycle_force_miss (cache_precycle_force_miss),
    .cache_datao               (cache_datao),
    .cache_inhibit             (cache_inhibit),
    .WE_TLB                    (WE_TLB),
    .cache_datai               (cache_datai),
    .cache_busy                (cache_busy),
    .MMU_FAULT                 (MMU_FAULT),
    .lookup_en                 (lookup_en),
    .arr_rd_idx                (arr_rd_idx),
    .tlb_rd_idx                (tlb_rd_idx),
    .cmp_tag                   (cmp_tag),
    .vpage                     (vpage),
    .hit                       (hit),
    .rd_data                   (rd_data),
    .ppage                     (ppage),
    .fault                     (fault),
    .arr_wr_en                 (arr_wr_en),
    .arr_wr_idx                (arr_wr_idx),
    .arr_wr_tag                (arr_wr_tag),
    .arr_wr_data               (arr_wr_data),
    .tlb_wr_en                 (tlb_wr_en),
    .tlb_wr_idx                (tlb_wr_idx),
    .tlb_wr_entry              (tlb_wr_entry),
    .bus_start                 (bus_start),
    .bus_req                   (bus_req),
    .bus_rsp                   (bus_rsp)
  );

  snowball_bus_unit u_bus
  (
    .CPU_CLK         (CPU_CLK),
    .RST             (RST),
    .bus_start       (bus_start),
    .bus_req         (bus_req),
    .bus_rsp         (bus_rsp),
    .mem_addr        (mem_addr),
    .mem_we          (mem_we),
    .mem_do_act      (mem_do_act),
    .mem_dataintomem (mem_dataintomem),
    .mem_ack         (mem_ack),
    .mem_datafrommem (mem_datafrommem),
    .dma_wrte        (dma_wrte),
    .dma_read        (dma_read),
    .dma_wrte_ack    (dma_wrte_ack),
    .dma_read_ack    (dma_read_ack),
    .dma_data_read   (dma_data_read)
  );

endmodule

`default_nettype wire

// File: design/snowball_pkg.sv
// Cache subsystem types
`default_nettype none
`include "snowball_defines.svh"

package snowball_pkg;

  // request as captured on the precycle strobe
  typedef struct packed {
    logic [`SNOWBALL_ADDR_W-1:0] addr; // virtual address
    logic [`SNOWBALL_ADDR_W-1:0] data; // write data
    logic                        we;
    logic                        force_miss;
  } cache_req_t;

  // one bus transfer, always at the physical address
  typedef struct packed {
    logic [`SNOWBALL_ADDR_W-1:0] addr;
    logic [`SNOWBALL_ADDR_W-1:0] data;
    logic                        we;
  } bus_req_t;

  typedef struct packed {
    logic                        done; // one cycle pulse
    logic [`SNOWBALL_ADDR_W-1:0] data; // read data, valid with done
  } bus_rsp_t;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_LOOKUP, // storage outputs valid, hit and fault decided
    CTRL_BUS, // start pulse to the bus unit
    CTRL_FILL // wait for done, then update the line
  } ctrl_state_e;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_MEM,
    BUS_DMA
  } bus_state_e;

endpackage

`default_nettype wire

// File: design/snowball_tlb.sv
// Translation table
`timescale 1ns/1ps
`default_nettype none
`include "snowball_defines.svh"

module snowball_tlb
(
  input  wire                          CPU_CLK,
  input  wire                          RST,
  input  wire  [`SNOWBALL_IDX_W-1:0]   rd_idx,
  input  wire                          rd_en,
  input  wire                          wr_en,
  input  wire  [`SNOWBALL_IDX_W-1:0]   wr_idx,
  input  wire  [`SNOWBALL_ADDR_W-1:0]  wr_entry,
  input  wire  [`SNOWBALL_PAGE_W-1:0]  vpage,
  input  wire                          vmem,
  output logic [`SNOWBALL_PAGE_W-1:0]  ppage,
  output logic                         fault
);

  logic [`SNOWBALL_PAGE_W-1:0] ppage_mem [0:`SNOWBALL_DEPTH-1];
  logic [`SNOWBALL_PAGE_W-1:0] vtag_mem  [0:`SNOWBALL_DEPTH-1];
  logic [`SNOWBALL_PAGE_W-1:0] ppage_q;
  logic [`SNOWBALL_PAGE_W-1:0] vtag_q;
  logic                        vmem_q;

  // entry word is {physical page, virtual tag}
  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      ppage_mem[wr_idx] <= wr_entry[`SNOWBALL_ADDR_W-1:`SNOWBALL_PAGE_W];
      vtag_mem[wr_idx]  <= wr_entry[`SNOWBALL_PAGE_W-1:0];
    end
    if (rd_en)
    begin
      ppage_q <= ppage_mem[rd_idx];
      vtag_q  <= vtag_mem[rd_idx];
    end
  end

  // translation mode is taken together with the request
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      vmem_q <= 1'b0;
    else if (rd_en)
      vmem_q <= vmem;
  end

  assign ppage = vmem_q ? ppage_q : vpage; // identity map when off
  assign fault = vmem_q && (vtag_q != vpage);

endmodule

`default_nettype wire

// File: include/snowball_defines.svh
// Cache subsystem widths
`ifndef SNOWBALL_DEFINES_SVH
`define SNOWBALL_DEFINES_SVH

// ------------------------------------------------------------
// address and storage geometry
// ------------------------------------------------------------
`define SNOWBALL_ADDR_W 32 // word address and data width
`define SNOWBALL_IDX_W 8 // line index, address bits 7:0
`define SNOWBALL_TAG_W 24 // physical address bits 31:8
`define SNOWBALL_PAGE_W 16 // page number, address bits 31:16
`define SNOWBALL_DEPTH (1 << `SNOWBALL_IDX_W) // lines and table entries

// ------------------------------------------------------------
// bus regions, decoded from address bits 31:30
// ------------------------------------------------------------
`define SNOWBALL_DMA_REGION 2'b11 // everything else is main memory

`endif

// File: project.f
+incdir+include
design/snowball_pkg.sv
design/snowball_tlb.sv
design/snowball_cache_array.sv
design/snowball_cache_ctrl.sv
design/snowball_bus_unit.sv
design/snowball_cache_top.sv
sim/snowball_checker.sv
sim/snowball_tb.sv

// File: sim/snowball_checker.sv
// Bus protocol checker
`timescale 1ns/1ps
`default_nettype none

module snowball_checker
(
  input wire CPU_CLK,
  input wire RST,
  input wire mem_do_act,
  input wire mem_ack,
  input wire dma_wrte,
  input wire dma_read,
  input wire dma_wrte_ack,
  input wire dma_read_ack
);

  int assert_fails = 0; // watched by the testbench

  // ------------------------------------------------------------
  // target strobes
  // ------------------------------------------------------------
  one_target: assert property (@(posedge CPU_CLK) disable iff (!RST)
    !(mem_do_act && (dma_wrte || dma_read)))
    else begin $error("memory and DMA strobes high together"); assert_fails++; end

  mem_held: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (mem_do_act && !mem_ack) |=> mem_do_act)
    else begin $error("mem_do_act dropped before mem_ack"); assert_fails++; end

  dma_rd_held: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (dma_read && !dma_read_ack) |=> dma_read)
    else begin $error("dma_read dropped before dma_read_ack"); assert_fails++; end

  dma_wr_held: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (dma_wrte && !dma_wrte_ack) |=> dma_wrte)
    else begin $error("dma_wrte dropped before dma_wrte_ack"); assert_fails++; end

  // sync reset, strobes are clear one cycle into reset
  quiet_in_reset: assert property (@(posedge CPU_CLK)
    !RST |=> (!mem_do_act && !dma_wrte && !dma_read))
    else begin $error("target strobe high during reset"); assert_fails++; end

endmodule

bind snowball_cache_top snowball_checker u_checker
(
  .CPU_CLK      (CPU_CLK),
  .RST          (RST),
  .mem_do_act   (mem_do_act),
  .mem_ack      (mem_ack),
  .dma_wrte     (dma_wrte),
  .dma_read     (dma_read),
  .dma_wrte_ack (dma_wrte_ack),
  .dma_read_ack (dma_read_ack)
);

`default_nettype wire

// File: sim/snowball_tb.sv
// Cache subsystem testbench
`timescale 1ns/1ps
`default_nettype none
`include "snowball_defines.svh"

module snowball_tb;

  localparam int WAIT_LIMIT = 50; // cycles per busy wait

  logic                        CPU_CLK;
  logic                        RST;
  logic [`SNOWBALL_ADDR_W-1:0] cache_precycle_addr;
  logic [`SNOWBALL_ADDR_W-1:0] cache_datao;
  logic [`SNOWBALL_ADDR_W-1:0] cache_datai;
  logic                        cache_precycle_we;
  logic                        cache_busy;
  logic                        cache_precycle_enable;
  logic                        cache_precycle_force_miss;
  logic                        VMEM_ACT;
  logic                        cache_inhibit;
  logic                        MMU_FAULT;
  logic                        WE_TLB;
  logic [`SNOWBALL_ADDR_W-1:0] mem_addr;
  logic                        mem_we;
  logic                        mem_do_act;
  logic [`SNOWBALL_ADDR_W-1:0] mem_dataintomem;
  logic                        mem_ack;
  logic [`SNOWBALL_ADDR_W-1:0] mem_datafrommem;
  logic                        dma_wrte;
  logic                        dma_read;
  logic                        dma_wrte_ack;
  logic                        dma_read_ack;
  logic [`SNOWBALL_ADDR_W-1:0] dma_data_read;

  // model state and strobe counters
  logic [31:0] mem_words [logic [31:0]];
  int          mem_rd_count = 0;
  int          mem_wr_count = 0;
  int          dma_rd_count = 0;
  int          dma_wr_count = 0;
  logic [31:0] last_addr;
  logic [31:0] last_wdata;
  logic        mem_pending;
  logic        dma_pending;
  int          mem_wait;
  int          dma_wait;

  snowball_cache_top u_snowball_cache_top (.*);

  initial
  begin
    CPU_CLK = 1'b0;
    forever #20 CPU_CLK = ~CPU_CLK;
  end

  // ------------------------------------------------------------
  // memory and DMA models, ack after 1 to 4 cycles
  // ------------------------------------------------------------
  initial
  begin
    mem_ack         = 1'b0;
    mem_datafrommem = '0;
    dma_wrte_ack    = 1'b0;
    dma_read_ack    = 1'b0;
    dma_data_read   = '0;
    mem_pending     = 1'b0;
    dma_pending     = 1'b0;
    void'($urandom(32'hb83f3430));
    forever
    begin
      @(posedge CPU_CLK);
      #1;
      mem_ack      = 1'b0;
      dma_wrte_ack = 1'b0;
      dma_read_ack = 1'b0;
      if (mem_do_act && !mem_pending)
      begin
        mem_pending = 1'b1;
        mem_wait    = 1 + ($urandom % 4);
      end
      if (mem_pending)
        mem_wait--;
      if (mem_pending && (mem_wait == 0))
      begin
        mem_pending = 1'b0;
        mem_ack     = 1'b1;
        last_addr   = mem_addr;
        if (mem_we)
        begin
          mem_words[mem_addr] = mem_dataintomem; // remembered for later reads
          last_wdata          = mem_dataintomem;
          mem_wr_count++;
        end
        else
        begin
          mem_datafrommem = mem_words.exists(mem_addr) ? mem_words[mem_addr]
                                                       : mem_addr ^ 32'h5a5a0000;
          mem_rd_count++;
        end
      end
      if ((dma_read || dma_wrte) && !dma_pending)
      begin
        dma_pending = 1'b1;
        dma_wait    = 1 + ($urandom % 4);
      end
      if (dma_pending)
        dma_wait--;
      if (dma_pending && (dma_wait == 0))
      begin
        dma_pending   = 1'b0;
        last_addr     = mem_addr;
        last_wdata    = mem_dataintomem;
        dma_data_read = mem_addr ^ 32'h0000c3c3;
        dma_read_ack  = dma_read;
        dma_wrte_ack  = dma_wrte;
        if (dma_read)
          dma_rd_count++;
        else
          dma_wr_count++;
      end
    end
  end

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // bus assertion failures end the run at the next clock
  always @(posedge CPU_CLK)
  begin
    if (u_snowball_cache_top.u_checker.assert_fails != 0)
    begin
      $display("bus protocol assertion failed");
      stop_with_failure();
    end
  end

  // ------------------------------------------------------------
  // CPU side drivers, entered and left at posedge + 1
  // ------------------------------------------------------------
  task automatic cpu_access(input logic [31:0] addr, input logic we, input logic [31:0] wdata,
                            input logic force_miss, output logic [31:0] rdata,
                            output logic busy_seen, output logic fault_seen);
    int waited;
    cache_precycle_enable     = 1'b1; // cycle N
    cache_precycle_addr       = addr;
    cache_precycle_we         = we;
    cache_datao               = wdata;
    cache_precycle_force_miss = force_miss;
    @(posedge CPU_CLK);
    #1;
    cache_precycle_enable     = 1'b0;
    cache_precycle_we         = 1'b0;
    cache_precycle_force_miss = 1'b0;
    @(posedge CPU_CLK);
    #1;
    busy_seen  = cache_busy; // N+2
    fault_seen = MMU_FAULT;
    waited     = 0;
    while (cache_busy)
    begin
      @(posedge CPU_CLK);
      #1;
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        $display("timeout: cache_busy never fell for address %h", addr);
        stop_with_failure();
      end
    end
    rdata = cache_datai;
  endtask

  task automatic table_write(input logic [7:0] idx, input logic [31:0] entry);
    WE_TLB              = 1'b1;
    cache_precycle_addr = {24'h0, idx};
    cache_datao         = entry;
    @(posedge CPU_CLK);
    #1;
    WE_TLB = 1'b0;
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic read_miss_then_hit();
    logic [31:0] rdata;
    logic        busy_seen;
    logic        fault_seen;
    int          reads;
    reads = mem_rd_count;
    cpu_access(32'h0000_1234, 1'b0, '0, 1'b0, rdata, busy_seen, fault_seen);
    check_value("first read busy", busy_seen, 1);
    check_value("first read data", rdata, 32'h0000_1234 ^ 32'h5a5a0000);
    check_value("first read memory reads", mem_rd_count - reads, 1);
    // another line, so the hit below has to reload cache_datai
    cpu_access(32'h0000_1238, 1'b0, '0, 1'b0, rdata, busy_seen, fault_seen);
    check_value("other line data", rdata, 32'h0000_1238 ^ 32'h5a5a0000);
    check_value("other line memory reads", mem_rd_count - reads, 2);
    cpu_access(32'h0000_1234, 1'b0, '0, 1'b0, rdata, busy_seen, fault_seen);
    check_value("hit busy", busy_seen, 0);
    check_value("hit data at N+2", rdata, 32'h0000_1234 ^ 32'h5a5a0000);
    check_value("hit memory reads", mem_rd_count - reads, 2);
    cpu_access(32'h0001_0034, 1'b0, '0, 1'b0, rdata, busy_seen, fault_seen);
    check_value("conflict read busy", busy_seen, 1);
    check_value("conflict read data", rdata, 32'h0001_0034 ^ 32'h5a5a0000);
    check_value("conflict memory reads", mem_rd_count - reads, 3);
  endtask

  task automatic write_through_readback();
    logic [31:0] rdata;
    logic        busy_seen;
    logic        fault_seen;
    int          writes;
    writes = mem_wr_count;
    cpu_access(32'h0000_2040, 1'b1, 32'hdeadbeef, 1'b0, rdata, busy_seen, fault_seen);
    check_value("write memory writes", mem_wr_count - writes, 1);
    check_value("write address", last_addr, 32'h0000_2040);
    check_value("write data", last_wdata, 32'hdeadbeef);
    cpu_access(32'h0000_2040, 1'b0, '0, 1'b0, rdata, busy_seen, fault_seen);
    check_value("read after write busy", busy_seen, 0);
    check_value("read after write data", rdata, 32'hdeadbeef);
  endtask

  task automatic dma_region_access();
    logic [31:0] rdata;
    logic        busy_seen;
    logic        fault_seen;
    int          mem_total;
    mem_total = mem_rd_count + mem_wr_count;
    cpu_access(32'hc000_0010, 1'b0, '0, 1'b0, rdata, busy_seen, fault_seen);
    check_value("dma read count", dma_rd_count, 1);
    check_value("dma read data", rdata, 32'hc000_0010 ^ 32'h0000c3c3);
    cpu_access(32'hc000_0020, 1'b1, 32'h1234_5678, 1'b0, rdata, busy_seen, fault_seen);
    check_value("dma write count", dma_wr_count, 1);
    check_value("dma write address", last_addr, 32'hc000_0020);
    check_value("dma write data", last_wdata, 32'h1234_5678);
    check_value("memory untouched by dma", mem_rd_count + mem_wr_count, mem_total);
  endtask

  task automatic force_miss_and_inhibit();
    logic [31:0] rdata;
    logic [31:0] old_datai;
    logic        busy_seen;
    logic        fault_seen;
    int          reads;
    int          total;
    reads = mem_rd_count;
    cpu_access(32'h0001_0034, 1'b0, '0, 1'b1, rdata, busy_seen, fault_seen);
    check_value("forced miss busy", busy_seen, 1);
    check_value("forced miss reads", mem_rd_count - reads, 1);
    check_value("forced miss data", rdata, 32'h0001_0034 ^ 32'h5a5a0000);
    total         = mem_rd_count + mem_wr_count + dma_rd_count + dma_wr_count;
    old_datai     = cache_datai;
    cache_inhibit = 1'b1;
    cpu_access(32'h0000_3300, 1'b0, '0, 1'b0, rdata, busy_seen, fault_seen);
    cache_inhibit = 1'b0;
    check_value("inhibit busy", busy_seen, 0);
    check_value("inhibit data", rdata, old_datai);
    check_value("inhibit accesses", mem_rd_count + mem_wr_count + dma_rd_count
                + dma_wr_count, total);
  endtask

  task automatic translate_and_fault();
    logic [31:0] rdata;
    logic [31:0] old_datai;
    logic        busy_seen;
    logic        fault_seen;
    int          total;
    table_write(8'h05, {16'h0023, 16'h0007}); // virtual page 7 to physical 23
    VMEM_ACT = 1'b1;
    cpu_access(32'h0007_0512, 1'b0, '0, 1'b0, rdata, busy_seen, fault_seen);
    check_value("translated address", last_addr, 32'h0023_0512);
    check_value("translated data", rdata, 32'h0023_0512 ^ 32'h5a5a0000);
    total     = mem_rd_count + mem_wr_count + dma_rd_count + dma_wr_count;
    old_datai = cache_datai;
    // same table entry, line 0x34 holds other data
    cpu_access(32'h0009_0534, 1'b0, '0, 1'b0, rdata, busy_seen, fault_seen);
    check_value("fault pulse", fault_seen, 1);
    check_value("fault busy", busy_seen, 0);
    check_value("fault data", rdata, old_datai);
    @(posedge CPU_CLK);
    #1;
    check_value("fault pulse width", MMU_FAULT, 0);
    check_value("fault accesses", mem_rd_count + mem_wr_count + dma_rd_count
                + dma_wr_count, total);
    VMEM_ACT = 1'b0;
  endtask

  initial
  begin
    RST                       = 1'b0;
    cache_precycle_addr       = '0;
    cache_datao               = '0;
    cache_precycle_we         = 1'b0;
    cache_precycle_enable     = 1'b0;
    cache_precycle_force_miss = 1'b0;
    VMEM_ACT                  = 1'b0;
    cache_inhibit             = 1'b0;
    WE_TLB                    = 1'b0;
    repeat (5) @(posedge CPU_CLK);
    #1;
    RST = 1'b1;
    check_value("busy after reset", cache_busy, 0);
    check_value("fault after reset", MMU_FAULT, 0);
    check_value("strobes after reset", {mem_do_act, mem_we, dma_wrte, dma_read}, 0);
    read_miss_then_hit();
    write_through_readback();
    dma_region_access();
    force_miss_and_inhibit();
    translate_and_fault();
    if (u_snowball_cache_top.u_checker.assert_fails == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
